// ==== logic/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	// timing counters and active coordinates
	localparam int cnt_w = 12;
	localparam int rgb_w = 24;
	localparam int chan_w = 8;
	localparam int div_w = 3;
	localparam int op_w = 4;
	localparam int pat_w = 2;

	////////////////////////////////////////////////////////////
	// enums
	////////////////////////////////////////////////////////////

	// register opcodes on the config port
	typedef enum logic [op_w-1:0] {
		cfg_h_sync,
		cfg_h_bp,
		cfg_h_act,
		cfg_h_fp,
		cfg_v_sync,
		cfg_v_bp,
		cfg_v_act,
		cfg_v_fp,
		cfg_pix_div,
		cfg_pattern,
		cfg_commit
	} cfg_op_e;

	typedef enum logic [pat_w-1:0] {
		pattern_black,
		pattern_bars,
		pattern_ramp,
		pattern_checker
	} pattern_e;

	////////////////////////////////////////////////////////////
	// structs
	////////////////////////////////////////////////////////////

	typedef struct packed {
		cfg_op_e          op;
		logic [cnt_w-1:0] data;
	} cfg_req_t;

	// one complete timing set, periods in pixel clocks or lines
	typedef struct packed {
		logic [cnt_w-1:0] h_sync;
		logic [cnt_w-1:0] h_bp;
		logic [cnt_w-1:0] h_act;
		logic [cnt_w-1:0] h_fp;
		logic [cnt_w-1:0] v_sync;
		logic [cnt_w-1:0] v_bp;
		logic [cnt_w-1:0] v_act;
		logic [cnt_w-1:0] v_fp;
		logic [div_w-1:0] pix_div;
		pattern_e         pattern;
	} vid_cfg_t;

	typedef struct packed {
		logic             hs;
		logic             vs;
		logic             de;
		logic             valid;
		logic [cnt_w-1:0] x;
		logic [cnt_w-1:0] y;
	} vid_timing_t;

	typedef struct packed {
		logic             hs;
		logic             vs;
		logic             de;
		logic             valid;
		logic [rgb_w-1:0] rgb;
	} vid_pixel_t;

	// 640x480 standard timing, bars
	localparam vid_cfg_t cfg_default = '{
		h_sync: 12'd96, h_bp: 12'd48, h_act: 12'd640, h_fp: 12'd16,
		v_sync: 12'd2, v_bp: 12'd33, v_act: 12'd480, v_fp: 12'd10,
		pix_div: 3'd1, pattern: pattern_bars
	};

	// blank stream, syncs idle high
	localparam vid_timing_t timing_idle = '{
		hs: 1'b1, vs: 1'b1, de: 1'b0, valid: 1'b0, x: '0, y: '0
	};

	localparam vid_pixel_t pixel_idle = '{
		hs: 1'b1, vs: 1'b1, de: 1'b0, valid: 1'b0, rgb: '0
	};

endpackage

`default_nettype wire

// ==== logic/vga_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_cfg_regs
	import vga_pkg::*;
(
	input  logic     in_pclk,
	input  logic     in_rstn,
	input  logic     cfg_valid,
	input  cfg_req_t cfg_req,
	output logic     cfg_ready,
	input  logic     frame_start,
	output vid_cfg_t active_cfg,
	output logic     run
);

	vid_cfg_t staging_cfg;
	vid_cfg_t pending_cfg;
	logic     pending;
	logic     cfg_fire;
	logic     is_commit;
	logic     apply;
	logic [div_w-1:0] div_field;

	// port stalls while a committed set waits for its frame
	assign cfg_ready = !pending;
	assign cfg_fire = cfg_valid && cfg_ready;
	assign is_commit = cfg_fire && (cfg_req.op == cfg_commit);

	// swap at the boundary, or right away before the raster runs
	assign apply = pending && (frame_start || !run);

	// divide by zero makes no sense, clamp to 1
	assign div_field = (cfg_req.data[div_w-1:0] == '0) ? div_w'(1)
		: cfg_req.data[div_w-1:0];

	////////////////////////////////////////////////////////////
	// staging set
	////////////////////////////////////////////////////////////

	always_ff @(posedge in_pclk)
	begin
		if (!in_rstn)
		begin
			staging_cfg <= cfg_default;
		end
		else if (cfg_fire)
		begin
			case (cfg_req.op)
				cfg_h_sync:  staging_cfg.h_sync <= cfg_req.data;
				cfg_h_bp:    staging_cfg.h_bp <= cfg_req.data;
				cfg_h_act:   staging_cfg.h_act <= cfg_req.data;
				cfg_h_fp:    staging_cfg.h_fp <= cfg_req.data;
				cfg_v_sync:  staging_cfg.v_sync <= cfg_req.data;
				cfg_v_bp:    staging_cfg.v_bp <= cfg_req.data;
				cfg_v_act:   staging_cfg.v_act <= cfg_req.data;
				cfg_v_fp:    staging_cfg.v_fp <= cfg_req.data;
				cfg_pix_div: staging_cfg.pix_div <= div_field;
				cfg_pattern: staging_cfg.pattern <= pattern_e'(cfg_req.data[pat_w-1:0]);
				// commit and unused codes leave staging alone
				default:     staging_cfg <= staging_cfg;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// pending and active sets
	////////////////////////////////////////////////////////////

	// snapshot on commit
	always_ff @(posedge in_pclk)
	begin
		if (is_commit)
		begin
			pending_cfg <= staging_cfg;
		end
	end

	always_ff @(posedge in_pclk)
	begin
		if (!in_rstn)
		begin
			pending <= 1'b0;
			run <= 1'b0;
			active_cfg <= cfg_default;
		end
		else
		begin
			// commit only lands while nothing is pending, so no overlap with apply
			if (is_commit)
			begin
				pending <= 1'b1;
			end
			else if (apply)
			begin
				pending <= 1'b0;
			end

			if (apply)
			begin
				active_cfg <= pending_cfg;
				// first commit starts the raster, it never stops afterwards
				run <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/vga_timing_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_timing_gen
	import vga_pkg::*;
(
	input  logic        in_pclk,
	input  logic        in_rstn,
	input  vid_cfg_t    active_cfg,
	input  logic        run,
	output logic        frame_start,
	output vid_timing_t timing
);

	// derived periods and enable windows
	logic [cnt_w-1:0] h_total;
	logic [cnt_w-1:0] h_de_start;
	logic [cnt_w-1:0] h_de_end;
	logic [cnt_w-1:0] v_total;
	logic [cnt_w-1:0] v_de_start;
	logic [cnt_w-1:0] v_de_end;

	logic [cnt_w-1:0] h_cnt;
	logic [cnt_w-1:0] v_cnt;
	logic             h_last;
	logic             v_last;
	logic             h_en;
	logic             v_en;

	logic [div_w-1:0] div_cnt;
	logic [cnt_w-1:0] x_cnt;
	logic [cnt_w-1:0] y_cnt;
	logic             de_fall;

	// stage0 is decoded straight from the counters
	vid_timing_t stage0;
	vid_timing_t stage1;
	vid_timing_t stage2;

	////////////////////////////////////////////////////////////
	// period decode
	////////////////////////////////////////////////////////////

	assign h_de_start = active_cfg.h_sync + active_cfg.h_bp;
	assign h_de_end = h_de_start + active_cfg.h_act;
	assign h_total = h_de_end + active_cfg.h_fp;

	assign v_de_start = active_cfg.v_sync + active_cfg.v_bp;
	assign v_de_end = v_de_start + active_cfg.v_act;
	assign v_total = v_de_end + active_cfg.v_fp;

	assign h_last = (h_cnt == h_total - 1'b1);
	assign v_last = (v_cnt == v_total - 1'b1);

	assign h_en = (h_cnt >= h_de_start) && (h_cnt < h_de_end);
	// vertical enable, whole active lines
	assign v_en = (v_cnt >= v_de_start) && (v_cnt < v_de_end);

	// config swap happens on this edge
	assign frame_start = run && h_last && v_last;

	////////////////////////////////////////////////////////////
	// raster counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge in_pclk)
	begin
		if (!in_rstn || !run)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else if (h_last)
		begin
			h_cnt <= '0;
			if (v_last)
			begin
				v_cnt <= '0;
			end
			else
			begin
				v_cnt <= v_cnt + 1'b1;
			end
		end
		else
		begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// syncs idle high while stopped
	always_comb
	begin
		stage0.hs = !run || (h_cnt >= active_cfg.h_sync);
		stage0.vs = !run || (v_cnt >= active_cfg.v_sync);
		stage0.de = run && h_en && v_en;
		stage0.valid = stage0.de && (div_cnt == '0);
		stage0.x = x_cnt;
		stage0.y = y_cnt;
	end

	assign de_fall = stage1.de && !stage0.de;

	////////////////////////////////////////////////////////////
	// pixel divider and active coordinates
	////////////////////////////////////////////////////////////

	// down-counter, first de cycle is always valid
	always_ff @(posedge in_pclk)
	begin
		if (!in_rstn || !stage0.de)
		begin
			div_cnt <= '0;
			x_cnt <= '0;
		end
		else if (stage0.valid)
		begin
			div_cnt <= active_cfg.pix_div - 1'b1;
			x_cnt <= x_cnt + 1'b1;
		end
		else
		begin
			div_cnt <= div_cnt - 1'b1;
		end
	end

	// y steps at the end of each active line
	always_ff @(posedge in_pclk)
	begin
		if (!in_rstn || !run)
		begin
			y_cnt <= '0;
		end
		else if (de_fall)
		begin
			if (y_cnt == active_cfg.v_act - 1'b1)
			begin
				y_cnt <= '0;
			end
			else
			begin
				y_cnt <= y_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// output pipeline, two stages
	////////////////////////////////////////////////////////////

	always_ff @(posedge in_pclk)
	begin
		if (!in_rstn)
		begin
			stage1 <= timing_idle;
			stage2 <= timing_idle;
		end
		else
		begin
			stage1 <= stage0;
			stage2 <= stage1;
		end
	end

	assign timing = stage2;

endmodule

`default_nettype wire

// ==== logic/vga_pattern_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_pattern_gen
	import vga_pkg::*;
(
	input  logic        in_pclk,
	input  logic        in_rstn,
	input  pattern_e    pattern,
	input  vid_timing_t timing,
	output vid_pixel_t  pixel
);

	logic [chan_w-1:0] red;
	logic [chan_w-1:0] green;
	logic [chan_w-1:0] blue;
	logic              tile;
	logic [rgb_w-1:0]  rgb_nxt;
	vid_pixel_t        pixel_q;

	////////////////////////////////////////////////////////////
	// colour select
	////////////////////////////////////////////////////////////

	// checker tiles are 8x8 pixels
	assign tile = timing.x[3] ^ timing.y[3];

	always_comb
	begin
		red = '0;
		green = '0;
		blue = '0;
		case (pattern)
			pattern_bars:
			begin
				// eight bars repeating every 8 pixels
				red = {chan_w{timing.x[2]}};
				green = {chan_w{timing.x[1]}};
				blue = {chan_w{timing.x[0]}};
			end
			pattern_ramp:
			begin
				// grey ramp
				red = timing.x[chan_w-1:0];
				green = timing.x[chan_w-1:0];
				blue = timing.x[chan_w-1:0];
			end
			pattern_checker:
			begin
				red = {chan_w{tile}};
				green = {chan_w{tile}};
				blue = {chan_w{tile}};
			end
			default:
			begin
				red = '0;
				green = '0;
				blue = '0;
			end
		endcase
	end

	// nothing drawn in blanking
	always_comb
	begin
		if (timing.de)
		begin
			rgb_nxt = {red, green, blue};
		end
		else
		begin
			rgb_nxt = '0;
		end
	end

	////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////

	// sync flags move with the colour so relative timing holds
	always_ff @(posedge in_pclk)
	begin
		if (!in_rstn)
		begin
			pixel_q <= pixel_idle;
		end
		else
		begin
			pixel_q.hs <= timing.hs;
			pixel_q.vs <= timing.vs;
			pixel_q.de <= timing.de;
			pixel_q.valid <= timing.valid;
			pixel_q.rgb <= rgb_nxt;
		end
	end

	assign pixel = pixel_q;

endmodule

`default_nettype wire

// ==== logic/vga_video_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_video_top
	import vga_pkg::*;
(
	input  logic       in_pclk,
	input  logic       in_rstn,
	input  logic       cfg_valid,
	input  cfg_req_t   cfg_req,
	output logic       cfg_ready,
	output vid_pixel_t pixel
);

	vid_cfg_t    active_cfg;
	logic        run;
	logic        frame_start;
	vid_timing_t timing;

	// register block, hands settings over at frame boundaries
	vga_cfg_regs u_cfg_regs (
		.in_pclk     (in_pclk),
		.in_rstn     (in_rstn),
		.cfg_valid   (cfg_valid),
		.cfg_req     (cfg_req),
		.cfg_ready   (cfg_ready),
		.frame_start (frame_start),
		.active_cfg  (active_cfg),
		.run         (run)
	);

	// raster timing, 2 cycles behind the counters
	vga_timing_gen u_timing_gen (
		.in_pclk     (in_pclk),
		.in_rstn     (in_rstn),
		.active_cfg  (active_cfg),
		.run         (run),
		.frame_start (frame_start),
		.timing      (timing)
	);

	// one more stage, pixel out lags the counters by 3
	vga_pattern_gen u_pattern_gen (
		.in_pclk (in_pclk),
		.in_rstn (in_rstn),
		.pattern (active_cfg.pattern),
		.timing  (timing),
		.pixel   (pixel)
	);

endmodule

`default_nettype wire

// ==== dv/vga_video_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_video_checker
	import vga_pkg::*;
(
	input logic       in_pclk,
	input logic       in_rstn,
	input logic       cfg_valid,
	input cfg_req_t   cfg_req,
	input logic       cfg_ready,
	input logic       frame_start,
	input logic       run,
	input vid_pixel_t pixel
);

	// failed assertion count, summed into the final result
	int unsigned fail_cnt = 0;

	logic commit_fire;

	assign commit_fire = cfg_valid && cfg_ready && (cfg_req.op == cfg_commit);

	////////////////////////////////////////////////////////////
	// pixel stream
	////////////////////////////////////////////////////////////

	valid_in_de: assert property (@(posedge in_pclk) disable iff (!in_rstn)
		pixel.valid |-> pixel.de)
	else
	begin
		fail_cnt++;
		$error("valid high outside de");
	end

	// blanking carries black
	rgb_blank: assert property (@(posedge in_pclk) disable iff (!in_rstn)
		!pixel.de |-> (pixel.rgb == '0))
	else
	begin
		fail_cnt++;
		$error("rgb not zero while de is low");
	end

	////////////////////////////////////////////////////////////
	// config port and run flag
	////////////////////////////////////////////////////////////

	commit_stall: assert property (@(posedge in_pclk) disable iff (!in_rstn)
		commit_fire |=> !cfg_ready)
	else
	begin
		fail_cnt++;
		$error("cfg_ready still high after a commit");
	end

	// a pending set only leaves at the frame wrap once running
	pending_hold: assert property (@(posedge in_pclk) disable iff (!in_rstn)
		!cfg_ready && run && !frame_start |=> !cfg_ready)
	else
	begin
		fail_cnt++;
		$error("cfg_ready rose away from the frame boundary");
	end

	run_sticky: assert property (@(posedge in_pclk) disable iff (!in_rstn)
		run |=> run)
	else
	begin
		fail_cnt++;
		$error("run fell after it had risen");
	end

endmodule

`default_nettype wire

// ==== dv/vga_video_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_video_tb
	import vga_pkg::*;
();

	logic       in_pclk;
	logic       in_rstn;
	logic       cfg_valid;
	cfg_req_t   cfg_req;
	logic       cfg_ready;
	vid_pixel_t pixel;

	int       cyc = 0;
	int       cycle_limit;
	int       errors;
	int       tests_run;
	int       tests_failed;
	int       errors_at_start;
	int       f0;
	int       rise_cyc;
	logic     hs_last;
	logic     vs_last;
	logic     rdy_last;
	vid_cfg_t cfg;
	vid_cfg_t cfg_b;

	vga_video_top UUT (
		.in_pclk   (in_pclk),
		.in_rstn   (in_rstn),
		.cfg_valid (cfg_valid),
		.cfg_req   (cfg_req),
		.cfg_ready (cfg_ready),
		.pixel     (pixel)
	);

	bind vga_video_top vga_video_checker u_checker (
		.in_pclk     (in_pclk),
		.in_rstn     (in_rstn),
		.cfg_valid   (cfg_valid),
		.cfg_req     (cfg_req),
		.cfg_ready   (cfg_ready),
		.frame_start (frame_start),
		.run         (run),
		.pixel       (pixel)
	);

	always #2 in_pclk = ~in_pclk;

	always @(posedge in_pclk)
	begin
		cyc <= cyc + 1;
		if (cyc >= cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// bookkeeping
	////////////////////////////////////////////////////////////

	function automatic int total_errors();
		return errors + int'(UUT.u_checker.fail_cnt);
	endfunction

	task automatic log_failure(input string msg);
		$display("FAIL %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (total_errors() == errors_at_start)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, total_errors() - errors_at_start);
		end
		errors_at_start = total_errors();
	endtask

	////////////////////////////////////////////////////////////
	// expected values from the timing and pattern rules
	////////////////////////////////////////////////////////////

	function automatic vid_cfg_t make_cfg(input int h_act, input int h_fp, input int v_act,
		input int div, input pattern_e pat);
		vid_cfg_t c;
		c.h_sync = 12'd4;
		c.h_bp = 12'd3;
		c.h_act = cnt_w'(h_act);
		c.h_fp = cnt_w'(h_fp);
		c.v_sync = 12'd2;
		c.v_bp = 12'd2;
		c.v_act = cnt_w'(v_act);
		c.v_fp = 12'd1;
		c.pix_div = div_w'(div);
		c.pattern = pat;
		return c;
	endfunction

	function automatic int line_length(input vid_cfg_t c);
		return int'(c.h_sync) + int'(c.h_bp) + int'(c.h_act) + int'(c.h_fp);
	endfunction

	function automatic int frame_length(input vid_cfg_t c);
		return line_length(c) * (int'(c.v_sync) + int'(c.v_bp) + int'(c.v_act) + int'(c.v_fp));
	endfunction

	function automatic logic [rgb_w-1:0] expected_rgb(input pattern_e pat, input int x,
		input int y);
		logic [cnt_w-1:0] xv;
		logic [cnt_w-1:0] yv;
		xv = cnt_w'(x);
		yv = cnt_w'(y);
		case (pat)
			pattern_bars:    return {{8{xv[2]}}, {8{xv[1]}}, {8{xv[0]}}};
			pattern_ramp:    return {3{xv[7:0]}};
			pattern_checker: return (xv[3] != yv[3]) ? 24'hffffff : 24'h000000;
			default:         return '0;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// stimulus and frame checks
	////////////////////////////////////////////////////////////

	task automatic write_cfg(input cfg_op_e op, input logic [cnt_w-1:0] data);
		@(negedge in_pclk);
		cfg_valid = 1'b1;
		cfg_req.op = op;
		cfg_req.data = data;
		while (!cfg_ready)
			@(negedge in_pclk);
		@(negedge in_pclk);
		cfg_valid = 1'b0;
	endtask

	task automatic program_cfg(input vid_cfg_t c);
		write_cfg(cfg_h_sync, c.h_sync);
		write_cfg(cfg_h_bp, c.h_bp);
		write_cfg(cfg_h_act, c.h_act);
		write_cfg(cfg_h_fp, c.h_fp);
		write_cfg(cfg_v_sync, c.v_sync);
		write_cfg(cfg_v_bp, c.v_bp);
		write_cfg(cfg_v_act, c.v_act);
		write_cfg(cfg_v_fp, c.v_fp);
		write_cfg(cfg_pix_div, cnt_w'(c.pix_div));
		write_cfg(cfg_pattern, cnt_w'(c.pattern));
		write_cfg(cfg_commit, '0);
	endtask

	// returns on the sample where vs falls
	task automatic wait_frame_start();
		logic vs_prev;
		vs_prev = pixel.vs;
		@(negedge in_pclk);
		while (!(vs_prev && !pixel.vs))
		begin
			vs_prev = pixel.vs;
			@(negedge in_pclk);
		end
	endtask

	// starts on the vs fall sample, ends on the last sample of the frame
	task automatic check_frame(input vid_cfg_t c);
		int line_len;
		int h0;
		int v0;
		int act;
		int div;
		int line;
		int h;
		int off;
		int x_exp;
		int pulses;
		int last_x;
		logic de_exp;
		vid_pixel_t want;
		vid_timing_t tim_last;
		line_len = line_length(c);
		h0 = int'(c.h_sync) + int'(c.h_bp);
		v0 = int'(c.v_sync) + int'(c.v_bp);
		act = int'(c.h_act);
		div = int'(c.pix_div);
		pulses = 0;
		last_x = -1;
		tim_last = UUT.timing;
		for (int t = 0; t < frame_length(c); t++)
		begin
			if (t > 0)
				@(negedge in_pclk);
			line = t / line_len;
			h = t % line_len;
			off = h - h0;
			de_exp = (off >= 0) && (off < act) && (line >= v0) && (line < v0 + int'(c.v_act));
			x_exp = de_exp ? (off + div - 1) / div : 0;
			want.hs = (h >= int'(c.h_sync));
			want.vs = (line >= int'(c.v_sync));
			want.de = de_exp;
			want.valid = de_exp && (off % div == 0);
			want.rgb = de_exp ? expected_rgb(c.pattern, x_exp, line - v0) : '0;
			assert (pixel == want)
			else
				log_failure($sformatf("line %0d col %0d: pixel %h, expected %h",
					line, h, pixel, want));
			// timing stream runs one cycle ahead of the pixel output
			if (want.valid)
			begin
				assert (tim_last.x == cnt_w'(x_exp) && tim_last.y == cnt_w'(line - v0))
				else
					log_failure($sformatf("line %0d col %0d: x %0d y %0d, expected %0d %0d",
						line, h, tim_last.x, tim_last.y, x_exp, line - v0));
			end
			// pulses as the DUT drives them
			if (pixel.valid)
			begin
				pulses++;
				last_x = int'(tim_last.x);
			end
			if (de_exp && off == act - 1)
			begin
				assert (pulses == (act + div - 1) / div && last_x == pulses - 1)
				else
					log_failure($sformatf("line %0d: %0d valid pulses, last x %0d",
						line, pulses, last_x));
				pulses = 0;
			end
			tim_last = UUT.timing;
		end
	endtask

	// commit right after a frame start, then check the next frame
	task automatic apply_and_check(input vid_cfg_t c);
		wait_frame_start();
		program_cfg(c);
		wait_frame_start();
		check_frame(c);
	endtask

	initial
	begin
		in_pclk = 1'b0;
		in_rstn = 1'b0;
		cfg_valid = 1'b0;
		cfg_req = '{op: cfg_h_sync, data: '0};
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		errors_at_start = 0;
		// twice the length of five tests of about four 500 cycle frames
		cycle_limit = 5 * 4 * 500 * 2;
		void'($urandom(32'hf942));
		repeat (8) @(negedge in_pclk);
		in_rstn = 1'b1;

		repeat (100)
		begin
			@(negedge in_pclk);
			assert (pixel.hs && pixel.vs && !pixel.de && !pixel.valid && pixel.rgb == '0
				&& cfg_ready)
			else
				log_failure("outputs left the idle state before any commit");
		end
		end_test("idle after reset");

		cfg = make_cfg(16, 2, 6, 1, pattern_bars);
		program_cfg(cfg);
		wait_frame_start();
		check_frame(cfg);
		end_test("frame timing and bars");

		repeat (2)
		begin
			cfg = make_cfg($urandom_range(20, 5), 2, 6, $urandom_range(4, 2), pattern_bars);
			apply_and_check(cfg);
		end
		end_test("pixel divider");

		// old frame keeps its line length while the new set waits
		cfg = make_cfg(16, 2, 6, 1, pattern_bars);
		cfg_b = make_cfg(16, 7, 6, 1, pattern_bars);
		apply_and_check(cfg);
		wait_frame_start();
		f0 = cyc;
		repeat (3 * line_length(cfg)) @(negedge in_pclk);
		program_cfg(cfg_b);
		assert (!cfg_ready)
		else
			log_failure("cfg_ready high with a commit pending");
		hs_last = pixel.hs;
		vs_last = pixel.vs;
		rdy_last = cfg_ready;
		rise_cyc = 0;
		@(negedge in_pclk);
		while (!(vs_last && !pixel.vs))
		begin
			assert (!(hs_last && !pixel.hs) || ((cyc - f0) % line_length(cfg) == 0))
			else
				log_failure("line length changed inside a frame");
			if (!rdy_last && cfg_ready)
				rise_cyc = cyc;
			hs_last = pixel.hs;
			vs_last = pixel.vs;
			rdy_last = cfg_ready;
			@(negedge in_pclk);
		end
		assert (cyc - f0 == frame_length(cfg))
		else
			log_failure($sformatf("frame with a pending commit lasted %0d cycles", cyc - f0));
		assert (cyc - rise_cyc == 3)
		else
			log_failure("cfg_ready released away from the frame boundary");
		check_frame(cfg_b);
		end_test("commit at frame boundary");

		cfg = make_cfg(20, 2, 12, 1, pattern_checker);
		apply_and_check(cfg);
		cfg.pattern = pattern_ramp;
		apply_and_check(cfg);
		end_test("checker and ramp patterns");

		$display("tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, total_errors());
		if (total_errors() == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vga_video.f ====
logic/vga_pkg.sv
logic/vga_cfg_regs.sv
logic/vga_timing_gen.sv
logic/vga_pattern_gen.sv
logic/vga_video_top.sv
dv/vga_video_checker.sv
dv/vga_video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vga_video testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f vga_video.f --top-module vga_video_tb -o vga_video_sim

# an early stop still leaves the output to be searched
out=$(./obj_dir/vga_video_sim +verilator+error+limit+1000 || true)
printf '%s\n' "$out"

echo "$out" | grep -qx "RESULT: PASS"
